// File: hdl/lsq_pkg.sv
`default_nettype none

package lsq_pkg;

	// Store queue geometry
	localparam int STQ_DEPTH = 8;
	localparam int STQ_PTR_W = 3;
	// Slot index with one wrap bit on top
	localparam int STQ_AGE_W = STQ_PTR_W + 1;

	// Load buffer geometry
	localparam int LDB_DEPTH = 4;
	localparam int LDB_IDX_W = 2;

	// Payload widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int TAG_W = 6;

	// Load issue controller
	typedef enum logic [1:0]
	{
		state_idle,
		state_forward,
		state_cache_wait
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/ring_pointers.sv
`timescale 1ns/100ps
`default_nettype none

module ring_pointers
	import lsq_pkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 push,
	input  logic                 pop,
	output logic [STQ_AGE_W-1:0] head,
	output logic [STQ_AGE_W-1:0] tail,
	output logic                 full,
	output logic                 empty
);

	// Top bit flips each time a pointer wraps around the ring
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
		end
		else
		begin
			if (push)
				tail <= tail + 1'b1;
			if (pop)
				head <= head + 1'b1;
		end
	end

	assign empty = (head == tail);
	// Same slot but one lap apart
	assign full = (head[STQ_PTR_W-1:0] == tail[STQ_PTR_W-1:0]) &&
		(head[STQ_PTR_W] != tail[STQ_PTR_W]);

	// The owner must respect the flags
	a_no_overflow: assert property (@(posedge clock) disable iff (reset) push |-> !full);
	a_no_underflow: assert property (@(posedge clock) disable iff (reset) pop |-> !empty);

endmodule

`default_nettype wire

// File: hdl/store_queue.sv
`timescale 1ns/100ps
`default_nettype none

module store_queue
	import lsq_pkg::*;
(
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        st_disp_valid,
	output logic                        st_disp_ready,
	output logic [STQ_PTR_W-1:0]        st_disp_age,
	input  logic                        st_issue_valid,
	input  logic [STQ_PTR_W-1:0]        st_issue_age,
	input  logic [ADDR_W-1:0]           st_issue_addr,
	input  logic [DATA_W-1:0]           st_issue_data,
	input  logic                        st_retire,
	output logic                        cache_st_valid,
	output logic [ADDR_W-1:0]           cache_st_addr,
	output logic [DATA_W-1:0]           cache_st_data,
	input  logic                        cache_st_ready,
	output logic [STQ_AGE_W-1:0]        head_age,
	output logic [STQ_AGE_W-1:0]        tail_age,
	output logic                        store_empty,
	output logic                        head_advance,
	output logic [STQ_DEPTH-1:0]        slot_known,
	output logic [STQ_DEPTH*ADDR_W-1:0] slot_addr_flat,
	output logic [STQ_DEPTH*DATA_W-1:0] slot_data_flat
);

	logic [ADDR_W-1:0] slot_addr [STQ_DEPTH];
	logic [DATA_W-1:0] slot_data [STQ_DEPTH];
	logic [STQ_AGE_W-1:0] commit_cnt;
	logic [STQ_AGE_W-1:0] occupancy;
	logic [STQ_PTR_W-1:0] head_ptr;
	logic [STQ_PTR_W-1:0] issue_offset;
	logic [STQ_PTR_W-1:0] retire_slot;
	logic disp_fire;
	logic full;

	assign disp_fire = st_disp_valid && st_disp_ready;
	assign head_advance = cache_st_valid && cache_st_ready;

	ring_pointers u_ptrs
	(
		.clock(clock),
		.reset(reset),
		.push(disp_fire),
		.pop(head_advance),
		.head(head_age),
		.tail(tail_age),
		.full(full),
		.empty(store_empty)
	);

	assign head_ptr = head_age[STQ_PTR_W-1:0];
	assign st_disp_ready = !full;
	assign st_disp_age = tail_age[STQ_PTR_W-1:0];

	// A fresh slot has no address until its issue arrives
	always_ff @(posedge clock)
	begin
		if (reset)
			slot_known <= '0;
		else
		begin
			if (disp_fire)
				slot_known[st_disp_age] <= 1'b0;
			if (st_issue_valid)
				slot_known[st_issue_age] <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (st_issue_valid)
		begin
			slot_addr[st_issue_age] <= st_issue_addr;
			slot_data[st_issue_age] <= st_issue_data;
		end
	end

	// Committed stores not yet accepted by the cache
	always_ff @(posedge clock)
	begin
		if (reset)
			commit_cnt <= '0;
		else if (st_retire && !head_advance)
			commit_cnt <= commit_cnt + 1'b1;
		else if (!st_retire && head_advance)
			commit_cnt <= commit_cnt - 1'b1;
	end

	assign cache_st_valid = (commit_cnt != '0);
	assign cache_st_addr = slot_addr[head_ptr];
	assign cache_st_data = slot_data[head_ptr];

	genvar i;
	generate
		for (i = 0; i < STQ_DEPTH; i++)
		begin : g_flat
			assign slot_addr_flat[i*ADDR_W +: ADDR_W] = slot_addr[i];
			assign slot_data_flat[i*DATA_W +: DATA_W] = slot_data[i];
		end
	endgenerate

	assign occupancy = tail_age - head_age;
	assign issue_offset = st_issue_age - head_ptr;
	assign retire_slot = head_ptr + commit_cnt[STQ_PTR_W-1:0];

	// Retire takes the oldest uncommitted store, which must have an address
	a_retire_in_range: assert property (@(posedge clock) disable iff (reset)
		st_retire |-> (commit_cnt < occupancy) && slot_known[retire_slot]);
	// Issue only targets a slot that dispatch already handed out
	a_issue_in_range: assert property (@(posedge clock) disable iff (reset)
		st_issue_valid |-> ({1'b0, issue_offset} < occupancy));

endmodule

`default_nettype wire

// File: hdl/load_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module load_buffer
	import lsq_pkg::*;
(
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           ld_valid,
	output logic                           ld_ready,
	input  logic [ADDR_W-1:0]              ld_addr,
	input  logic [TAG_W-1:0]               ld_tag,
	input  logic [STQ_AGE_W-1:0]           tail_age,
	input  logic                           store_empty,
	input  logic [STQ_AGE_W-1:0]           head_age,
	input  logic                           head_advance,
	input  logic                           release_valid,
	input  logic [LDB_IDX_W-1:0]           release_idx,
	output logic [LDB_DEPTH-1:0]           entry_busy,
	output logic [LDB_DEPTH-1:0]           entry_old,
	output logic [LDB_DEPTH*STQ_AGE_W-1:0] entry_age,
	output logic [LDB_DEPTH*ADDR_W-1:0]    entry_addr,
	output logic [LDB_DEPTH*TAG_W-1:0]     entry_tag
);

	logic [LDB_IDX_W-1:0] alloc_idx;
	logic alloc;

	// Lowest free entry wins
	always_comb
	begin
		alloc_idx = '0;
		for (int i = LDB_DEPTH - 1; i >= 0; i--)
		begin
			if (!entry_busy[i])
				alloc_idx = LDB_IDX_W'(i);
		end
	end

	assign ld_ready = !(&entry_busy);
	assign alloc = ld_valid && ld_ready;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			entry_busy <= '0;
			entry_old <= '0;
		end
		else
		begin
			// Head store at the load's age leaves, nothing older is left
			for (int i = 0; i < LDB_DEPTH; i++)
			begin
				if (entry_busy[i] && head_advance &&
					entry_age[i*STQ_AGE_W +: STQ_AGE_W] == head_age)
					entry_old[i] <= 1'b1;
			end
			if (release_valid)
				entry_busy[release_idx] <= 1'b0;
			if (alloc)
			begin
				entry_busy[alloc_idx] <= 1'b1;
				// Empty queue at entry means no older store at all
				entry_old[alloc_idx] <= store_empty;
			end
		end
	end

	// Tail age makes the load younger than every store already dispatched
	always_ff @(posedge clock)
	begin
		if (alloc)
		begin
			entry_age[alloc_idx*STQ_AGE_W +: STQ_AGE_W] <= tail_age;
			entry_addr[alloc_idx*ADDR_W +: ADDR_W] <= ld_addr;
			entry_tag[alloc_idx*TAG_W +: TAG_W] <= ld_tag;
		end
	end

	// Controller only frees loads it took from a live entry
	a_release_busy: assert property (@(posedge clock) disable iff (reset)
		release_valid |-> entry_busy[release_idx]);

endmodule

`default_nettype wire

// File: hdl/forward_check.sv
`timescale 1ns/100ps
`default_nettype none

module forward_check
	import lsq_pkg::*;
(
	input  logic [STQ_AGE_W-1:0]           head_age,
	input  logic [STQ_DEPTH-1:0]           slot_known,
	input  logic [STQ_DEPTH*ADDR_W-1:0]    slot_addr_flat,
	input  logic [LDB_DEPTH-1:0]           entry_busy,
	input  logic [LDB_DEPTH-1:0]           entry_old,
	input  logic [LDB_DEPTH*STQ_AGE_W-1:0] entry_age,
	input  logic [LDB_DEPTH*ADDR_W-1:0]    entry_addr,
	output logic [LDB_DEPTH-1:0]           entry_ready,
	output logic [LDB_DEPTH-1:0]           entry_match,
	output logic [LDB_DEPTH*STQ_PTR_W-1:0] entry_match_slot
);

	always_comb
	begin : scan
		logic [STQ_AGE_W-1:0] span;
		logic [STQ_PTR_W-1:0] slot;
		span = '0;
		slot = '0;
		entry_ready = '0;
		entry_match = '0;
		entry_match_slot = '0;
		for (int i = 0; i < LDB_DEPTH; i++)
		begin
			// Old entries stay ready with no match
			entry_ready[i] = entry_busy[i];
			// Count of stores between the head and the load's age
			span = entry_age[i*STQ_AGE_W +: STQ_AGE_W] - head_age;
			if (entry_busy[i] && !entry_old[i])
			begin
				// Oldest first, so the last hit is the youngest older store
				for (int j = 0; j < STQ_DEPTH; j++)
				begin
					slot = head_age[STQ_PTR_W-1:0] + STQ_PTR_W'(j);
					if (STQ_AGE_W'(j) < span)
					begin
						if (!slot_known[slot])
							entry_ready[i] = 1'b0;
						else if (slot_addr_flat[slot*ADDR_W +: ADDR_W] ==
							entry_addr[i*ADDR_W +: ADDR_W])
						begin
							entry_match[i] = 1'b1;
							entry_match_slot[i*STQ_PTR_W +: STQ_PTR_W] = slot;
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/load_issue_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module load_issue_ctrl
	import lsq_pkg::*;
(
	input  logic                           clock,
	input  logic                           reset,
	input  logic [LDB_DEPTH-1:0]           entry_ready,
	input  logic [LDB_DEPTH-1:0]           entry_match,
	input  logic [LDB_DEPTH*STQ_PTR_W-1:0] entry_match_slot,
	input  logic [LDB_DEPTH*ADDR_W-1:0]    entry_addr,
	input  logic [LDB_DEPTH*TAG_W-1:0]     entry_tag,
	input  logic [STQ_DEPTH*DATA_W-1:0]    slot_data_flat,
	output logic                           release_valid,
	output logic [LDB_IDX_W-1:0]           release_idx,
	output logic                           result_valid,
	output logic [TAG_W-1:0]               result_tag,
	output logic [DATA_W-1:0]              result_data,
	output logic                           cache_ld_valid,
	output logic [ADDR_W-1:0]              cache_ld_addr,
	output logic [TAG_W-1:0]               cache_ld_tag,
	input  logic                           cache_ld_ready
);

	ctrl_state_t state;
	logic [LDB_IDX_W-1:0] pick_idx;
	logic [STQ_PTR_W-1:0] pick_slot;
	logic pick_valid;
	logic [LDB_IDX_W-1:0] sel_idx;
	logic [TAG_W-1:0] sel_tag;
	logic [ADDR_W-1:0] sel_addr;
	logic [DATA_W-1:0] sel_data;

	// Lowest ready entry, ready already implies busy
	always_comb
	begin
		pick_idx = '0;
		pick_valid = 1'b0;
		for (int i = LDB_DEPTH - 1; i >= 0; i--)
		begin
			if (entry_ready[i])
			begin
				pick_idx = LDB_IDX_W'(i);
				pick_valid = 1'b1;
			end
		end
	end

	assign pick_slot = entry_match_slot[pick_idx*STQ_PTR_W +: STQ_PTR_W];

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= state_idle;
		else
		begin
			case (state)
				state_idle:
					if (pick_valid)
						state <= entry_match[pick_idx] ? state_forward : state_cache_wait;
				state_forward:
					state <= state_idle;
				state_cache_wait:
					if (cache_ld_ready)
						state <= state_idle;
				default:
					state <= state_idle;
			endcase
		end
	end

	// Chosen load and its forwarded data, held until it leaves
	always_ff @(posedge clock)
	begin
		if (state == state_idle && pick_valid)
		begin
			sel_idx <= pick_idx;
			sel_tag <= entry_tag[pick_idx*TAG_W +: TAG_W];
			sel_addr <= entry_addr[pick_idx*ADDR_W +: ADDR_W];
			sel_data <= slot_data_flat[pick_slot*DATA_W +: DATA_W];
		end
	end

	assign result_valid = (state == state_forward);
	assign result_tag = sel_tag;
	assign result_data = sel_data;
	assign cache_ld_valid = (state == state_cache_wait);
	assign cache_ld_addr = sel_addr;
	assign cache_ld_tag = sel_tag;
	// Entry frees on the result cycle or on the cache handshake
	assign release_valid = result_valid || (cache_ld_valid && cache_ld_ready);
	assign release_idx = sel_idx;

	a_cache_hold: assert property (@(posedge clock) disable iff (reset)
		cache_ld_valid && !cache_ld_ready |=>
		cache_ld_valid && $stable(cache_ld_addr) && $stable(cache_ld_tag));

endmodule

`default_nettype wire

// File: hdl/lsq_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsq_top
	import lsq_pkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 st_disp_valid,
	output logic                 st_disp_ready,
	output logic [STQ_PTR_W-1:0] st_disp_age,
	input  logic                 st_issue_valid,
	input  logic [STQ_PTR_W-1:0] st_issue_age,
	input  logic [ADDR_W-1:0]    st_issue_addr,
	input  logic [DATA_W-1:0]    st_issue_data,
	input  logic                 st_retire,
	input  logic                 ld_valid,
	output logic                 ld_ready,
	input  logic [ADDR_W-1:0]    ld_addr,
	input  logic [TAG_W-1:0]     ld_tag,
	output logic                 result_valid,
	output logic [TAG_W-1:0]     result_tag,
	output logic [DATA_W-1:0]    result_data,
	output logic                 cache_ld_valid,
	input  logic                 cache_ld_ready,
	output logic [ADDR_W-1:0]    cache_ld_addr,
	output logic [TAG_W-1:0]     cache_ld_tag,
	output logic                 cache_st_valid,
	input  logic                 cache_st_ready,
	output logic [ADDR_W-1:0]    cache_st_addr,
	output logic [DATA_W-1:0]    cache_st_data
);

	// Store queue state seen by the search and the load buffer
	logic [STQ_AGE_W-1:0] head_age;
	logic [STQ_AGE_W-1:0] tail_age;
	logic store_empty;
	logic head_advance;
	logic [STQ_DEPTH-1:0] slot_known;
	logic [STQ_DEPTH*ADDR_W-1:0] slot_addr_flat;
	logic [STQ_DEPTH*DATA_W-1:0] slot_data_flat;

	// Waiting loads
	logic [LDB_DEPTH-1:0] entry_busy;
	logic [LDB_DEPTH-1:0] entry_old;
	logic [LDB_DEPTH*STQ_AGE_W-1:0] entry_age;
	logic [LDB_DEPTH*ADDR_W-1:0] entry_addr;
	logic [LDB_DEPTH*TAG_W-1:0] entry_tag;

	// Search results and controller release
	logic [LDB_DEPTH-1:0] entry_ready;
	logic [LDB_DEPTH-1:0] entry_match;
	logic [LDB_DEPTH*STQ_PTR_W-1:0] entry_match_slot;
	logic release_valid;
	logic [LDB_IDX_W-1:0] release_idx;

	store_queue u_store_queue (.*);

	load_buffer u_load_buffer (.*);

	forward_check u_forward_check (.*);

	load_issue_ctrl u_load_issue_ctrl (.*);

endmodule

`default_nettype wire

// File: tb/lsq_tb_tests.svh
`ifndef LSQ_TB_TESTS_SVH
`define LSQ_TB_TESTS_SVH

	// Age is read while valid is up, the transfer is the following edge
	task automatic dispatch_store(output logic [STQ_PTR_W-1:0] age);
		@(posedge clock);
		st_disp_valid <= 1'b1;
		@(negedge clock);
		if (!st_disp_ready)
			report_failure("store queue refused a dispatch");
		age = st_disp_age;
		@(posedge clock);
		st_disp_valid <= 1'b0;
	endtask

	task automatic issue_store(input logic [STQ_PTR_W-1:0] age, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		@(posedge clock);
		st_issue_valid <= 1'b1;
		st_issue_age <= age;
		st_issue_addr <= addr;
		st_issue_data <= data;
		@(posedge clock);
		st_issue_valid <= 1'b0;
	endtask

	task automatic retire_store();
		@(posedge clock);
		st_retire <= 1'b1;
		@(posedge clock);
		st_retire <= 1'b0;
	endtask

	task automatic enter_load(input logic [ADDR_W-1:0] addr, input logic [TAG_W-1:0] tag);
		@(posedge clock);
		ld_valid <= 1'b1;
		ld_addr <= addr;
		ld_tag <= tag;
		@(negedge clock);
		if (!ld_ready)
			report_failure("load buffer refused a load");
		@(posedge clock);
		ld_valid <= 1'b0;
	endtask

	task automatic wait_result(output logic seen);
		int i;
		seen = 1'b0;
		for (i = 0; i < WAIT_LIMIT && !seen; i++)
		begin
			@(negedge clock);
			seen = result_valid;
		end
	endtask

	task automatic wait_cache_ld(output logic seen);
		int i;
		seen = 1'b0;
		for (i = 0; i < WAIT_LIMIT && !seen; i++)
		begin
			@(negedge clock);
			seen = cache_ld_valid;
		end
	endtask

	// Done once every committed store has left for the cache
	task automatic wait_drained(output logic seen);
		int i;
		seen = 1'b0;
		for (i = 0; i < WAIT_LIMIT && !seen; i++)
		begin
			@(negedge clock);
			seen = !cache_st_valid;
		end
	endtask

	task automatic test_after_reset();
		begin_test("after_reset");
		@(negedge clock);
		if (st_disp_ready !== 1'b1)
			report_mismatch("st_disp_ready", 1, st_disp_ready);
		if (ld_ready !== 1'b1)
			report_mismatch("ld_ready", 1, ld_ready);
		if (result_valid !== 1'b0)
			report_mismatch("result_valid", 0, result_valid);
		if (cache_ld_valid !== 1'b0)
			report_mismatch("cache_ld_valid", 0, cache_ld_valid);
		if (cache_st_valid !== 1'b0)
			report_mismatch("cache_st_valid", 0, cache_st_valid);
		if (st_disp_age !== '0)
			report_mismatch("st_disp_age", 0, st_disp_age);
		end_test();
	endtask

	task automatic test_forwarding();
		logic [STQ_PTR_W-1:0] age_a;
		logic [STQ_PTR_W-1:0] age_b;
		logic [STQ_PTR_W-1:0] age_c;
		logic [DATA_W-1:0] data_a;
		logic [DATA_W-1:0] data_b;
		logic [DATA_W-1:0] data_c;
		logic seen;
		begin_test("forwarding");
		random_word(data_a);
		random_word(data_b);
		random_word(data_c);
		dispatch_store(age_a);
		dispatch_store(age_b);
		issue_store(age_a, 32'h0000_2000, data_a);
		enter_load(32'h0000_2000, 6'd11);
		// Younger than the load, so its data is never a candidate
		dispatch_store(age_c);
		issue_store(age_c, 32'h0000_2000, data_c);
		issue_store(age_b, 32'h0000_2000, data_b);
		wait_result(seen);
		if (!seen)
			report_failure("no forwarded result arrived");
		else
		begin
			if (result_tag !== 6'd11)
				report_mismatch("result_tag", 11, result_tag);
			// Youngest older store at the same address
			if (result_data !== data_b)
				report_mismatch("result_data", data_b, result_data);
		end
		repeat (3) retire_store();
		wait_drained(seen);
		if (!seen)
			report_failure("retired stores did not drain");
		end_test();
	endtask

	task automatic test_unknown_address();
		logic [STQ_PTR_W-1:0] age;
		logic [DATA_W-1:0] data;
		logic seen;
		begin_test("unknown_address");
		random_word(data);
		dispatch_store(age);
		enter_load(32'h0000_3000, 6'd17);
		repeat (10)
		begin
			@(negedge clock);
			if (result_valid || cache_ld_valid)
				report_failure("load left before the older store address was known");
		end
		issue_store(age, 32'h0000_3800, data);
		wait_cache_ld(seen);
		if (!seen)
			report_failure("no cache load request after the store issued");
		else
		begin
			if (cache_ld_addr !== 32'h0000_3000)
				report_mismatch("cache_ld_addr", 32'h3000, cache_ld_addr);
			if (cache_ld_tag !== 6'd17)
				report_mismatch("cache_ld_tag", 17, cache_ld_tag);
		end
		retire_store();
		wait_drained(seen);
		if (!seen)
			report_failure("retired store did not drain");
		end_test();
	endtask

	task automatic test_cache_backpressure();
		int first_count;
		int second_count;
		int i;
		logic seen;
		begin_test("cache_backpressure");
		first_count = 0;
		second_count = 0;
		@(posedge clock);
		cache_ld_ready <= 1'b0;
		enter_load(32'h0000_4000, 6'd21);
		// Second load queues up behind the stalled request
		enter_load(32'h0000_4040, 6'd22);
		wait_cache_ld(seen);
		if (!seen)
			report_failure("no cache load request appeared");
		repeat (6)
		begin
			@(negedge clock);
			if (!cache_ld_valid)
				report_failure("cache load request dropped while stalled");
			if (cache_ld_addr !== 32'h0000_4000)
				report_mismatch("stalled cache_ld_addr", 32'h4000, cache_ld_addr);
			if (cache_ld_tag !== 6'd21)
				report_mismatch("stalled cache_ld_tag", 21, cache_ld_tag);
		end
		@(posedge clock);
		cache_ld_ready <= 1'b1;
		for (i = 0; i < WAIT_LIMIT && second_count == 0; i++)
		begin
			@(negedge clock);
			if (cache_ld_valid && cache_ld_ready)
			begin
				if (cache_ld_tag == 6'd21)
					first_count++;
				else if (cache_ld_tag == 6'd22)
				begin
					second_count++;
					if (cache_ld_addr !== 32'h0000_4040)
						report_mismatch("second cache_ld_addr", 32'h4040, cache_ld_addr);
				end
				else
					report_mismatch("cache_ld_tag", 22, cache_ld_tag);
			end
		end
		if (first_count != 1)
			report_mismatch("first load transfers", 1, first_count);
		if (second_count != 1)
			report_failure("second load never reached the cache");
		end_test();
	endtask

	task automatic test_retire_drain();
		logic [STQ_PTR_W-1:0] ages [STQ_DEPTH];
		logic [ADDR_W-1:0] addrs [STQ_DEPTH];
		logic [DATA_W-1:0] datas [STQ_DEPTH];
		logic seen;
		int i;
		begin_test("retire_drain");
		@(posedge clock);
		seen_st_addr.delete();
		seen_st_data.delete();
		toggle_st_ready <= 1'b1;
		for (i = 0; i < STQ_DEPTH; i++)
			dispatch_store(ages[i]);
		@(negedge clock);
		if (st_disp_ready !== 1'b0)
			report_mismatch("st_disp_ready when full", 0, st_disp_ready);
		for (i = 0; i < STQ_DEPTH; i++)
		begin
			addrs[i] = 32'h0000_8000 + 32'(i * 16);
			random_word(datas[i]);
			issue_store(ages[i], addrs[i], datas[i]);
		end
		for (i = 0; i < STQ_DEPTH; i++)
			retire_store();
		wait_drained(seen);
		if (!seen)
			report_failure("committed stores did not drain");
		@(posedge clock);
		toggle_st_ready <= 1'b0;
		@(posedge clock);
		cache_st_ready <= 1'b1;
		if (seen_st_addr.size() != STQ_DEPTH)
			report_mismatch("cache store transfers", STQ_DEPTH, seen_st_addr.size());
		else
		begin
			// Drain order must follow dispatch order
			for (i = 0; i < STQ_DEPTH; i++)
			begin
				if (seen_st_addr[i] !== addrs[i])
					report_mismatch("cache_st_addr", addrs[i], seen_st_addr[i]);
				if (seen_st_data[i] !== datas[i])
					report_mismatch("cache_st_data", datas[i], seen_st_data[i]);
			end
		end
		@(negedge clock);
		if (st_disp_ready !== 1'b1)
			report_mismatch("st_disp_ready after drain", 1, st_disp_ready);
		// Same address as a drained store, but nothing is left to forward
		enter_load(32'h0000_8010, 6'd40);
		wait_cache_ld(seen);
		if (!seen)
			report_failure("load after the drain never reached the cache");
		else
		begin
			if (cache_ld_addr !== 32'h0000_8010)
				report_mismatch("cache_ld_addr", 32'h8010, cache_ld_addr);
			if (cache_ld_tag !== 6'd40)
				report_mismatch("cache_ld_tag", 40, cache_ld_tag);
		end
		end_test();
	endtask

`endif

// File: tb/lsq_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsq_tb
	import lsq_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int WAIT_LIMIT = 40;

	logic clock;
	logic reset;
	logic st_disp_valid;
	logic st_disp_ready;
	logic [STQ_PTR_W-1:0] st_disp_age;
	logic st_issue_valid;
	logic [STQ_PTR_W-1:0] st_issue_age;
	logic [ADDR_W-1:0] st_issue_addr;
	logic [DATA_W-1:0] st_issue_data;
	logic st_retire;
	logic ld_valid;
	logic ld_ready;
	logic [ADDR_W-1:0] ld_addr;
	logic [TAG_W-1:0] ld_tag;
	logic result_valid;
	logic [TAG_W-1:0] result_tag;
	logic [DATA_W-1:0] result_data;
	logic cache_ld_valid;
	logic cache_ld_ready;
	logic [ADDR_W-1:0] cache_ld_addr;
	logic [TAG_W-1:0] cache_ld_tag;
	logic cache_st_valid;
	logic cache_st_ready;
	logic [ADDR_W-1:0] cache_st_addr;
	logic [DATA_W-1:0] cache_st_data;

	int error_count;
	int tests_run;
	int tests_failed;
	int test_start_errors;
	int cycle_count;
	string test_name;
	logic [15:0] lfsr_state;
	logic toggle_st_ready;
	logic [ADDR_W-1:0] seen_st_addr [$];
	logic [DATA_W-1:0] seen_st_data [$];

	lsq_top dut (.*);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Cache store port can be made to stall every other cycle
	always @(posedge clock)
	begin
		if (toggle_st_ready)
			cache_st_ready <= !cache_st_ready;
	end

	// Record every cache store transfer in arrival order
	always @(negedge clock)
	begin
		if (!reset && cache_st_valid && cache_st_ready)
		begin
			seen_st_addr.push_back(cache_st_addr);
			seen_st_data.push_back(cache_st_data);
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	task automatic random_word(output logic [DATA_W-1:0] word);
		int i;
		word = '0;
		for (i = 0; i < DATA_W; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			word = {word[DATA_W-2:0], lfsr_state[0]};
		end
	endtask

	task automatic report_mismatch(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		error_count++;
		$display("Error in %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
	endtask

	task automatic report_failure(input string msg);
		error_count++;
		$display("Failure in %s: %s", test_name, msg);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_start_errors = error_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (error_count == test_start_errors)
			$display("Test %s: passed", test_name);
		else
		begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", test_name,
				error_count - test_start_errors);
		end
	endtask

`include "lsq_tb_tests.svh"

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: tests still running after %0d cycles", cycle_count);
		$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		st_disp_valid = 1'b0;
		st_issue_valid = 1'b0;
		st_issue_age = '0;
		st_issue_addr = '0;
		st_issue_data = '0;
		st_retire = 1'b0;
		ld_valid = 1'b0;
		ld_addr = '0;
		ld_tag = '0;
		cache_ld_ready = 1'b1;
		cache_st_ready = 1'b1;
		toggle_st_ready = 1'b0;
		lfsr_state = 16'd27366;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		test_after_reset();
		test_forwarding();
		test_unknown_address();
		test_cache_backpressure();
		test_retire_drain();
		$display("Tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+tb
hdl/lsq_pkg.sv
hdl/ring_pointers.sv
hdl/store_queue.sv
hdl/load_buffer.sv
hdl/forward_check.sv
hdl/load_issue_ctrl.sv
hdl/lsq_top.sv
tb/lsq_tb.sv
